/* src/mcalu_pkg.sv */
// Shared widths, opcode table, iteration counts and sequencer states of the execution unit
package mcalu_pkg;

  // Operand and result word
  typedef logic [31:0] word_t;

  // Reorder-buffer tag
  typedef logic [6:0] robid_t;

  // Physical destination register
  typedef logic [5:0] rd_t;

  // Top two bits set means multi-cycle, then bit 2 picks divide
  typedef logic [4:0] alu_op_t;

  // Sequencer states shared by multiplier and divider
  typedef enum logic [1:0] {
    INIT,
    PROG,
    FINAL
  } mc_state_t;

  // Single-cycle group
  localparam alu_op_t OP_ADD    = 5'd0;
  localparam alu_op_t OP_SUB    = 5'd1;
  localparam alu_op_t OP_SLL    = 5'd2;
  localparam alu_op_t OP_SLT    = 5'd3;
  localparam alu_op_t OP_SLTU   = 5'd4;
  localparam alu_op_t OP_XOR    = 5'd5;
  localparam alu_op_t OP_SRL    = 5'd6;
  localparam alu_op_t OP_SRA    = 5'd7;
  localparam alu_op_t OP_OR     = 5'd8;
  localparam alu_op_t OP_AND    = 5'd9;

  // Multiply group, low bits give the operand signedness
  localparam alu_op_t OP_MUL    = 5'd24;
  localparam alu_op_t OP_MULH   = 5'd25;
  localparam alu_op_t OP_MULHSU = 5'd26;
  localparam alu_op_t OP_MULHU  = 5'd27;

  // Divide group, bit 0 unsigned and bit 1 remainder
  localparam alu_op_t OP_DIV    = 5'd28;
  localparam alu_op_t OP_DIVU   = 5'd29;
  localparam alu_op_t OP_REM    = 5'd30;
  localparam alu_op_t OP_REMU   = 5'd31;

  // Radix-4 steps over a 32-bit multiplier
  localparam int MUL_ITERS = 16;

  // One quotient bit per step
  localparam int DIV_ITERS = 32;

endpackage

/* src/alu_simple.sv */
// Combinational single-cycle logic, shift, compare and add/subtract operations
`timescale 1ns/1ps

module alu_simple (
  input  mcalu_pkg::alu_op_t op,
  input  mcalu_pkg::word_t   op1,
  input  mcalu_pkg::word_t   op2,
  output mcalu_pkg::word_t   sc_result
);

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  // Only the low five bits count for shifts
  assign shamt = op2[4:0];

  assign lt_signed   = $signed(op1) < $signed(op2);
  assign lt_unsigned = op1 < op2;

  always_comb begin
    case (op)
      mcalu_pkg::OP_ADD: begin
        sc_result = op1 + op2;
      end
      mcalu_pkg::OP_SUB: begin
        sc_result = op1 - op2;
      end
      mcalu_pkg::OP_SLL: begin
        sc_result = op1 << shamt;
      end
      mcalu_pkg::OP_SLT: begin
        sc_result = {31'b0, lt_signed};
      end
      mcalu_pkg::OP_SLTU: begin
        sc_result = {31'b0, lt_unsigned};
      end
      mcalu_pkg::OP_XOR: begin
        sc_result = op1 ^ op2;
      end
      mcalu_pkg::OP_SRL: begin
        sc_result = op1 >> shamt;
      end
      mcalu_pkg::OP_SRA: begin
        sc_result = $signed(op1) >>> shamt;
      end
      mcalu_pkg::OP_OR: begin
        sc_result = op1 | op2;
      end
      mcalu_pkg::OP_AND: begin
        sc_result = op1 & op2;
      end
      // Unknown codes return zero
      default: begin
        sc_result = '0;
      end
    endcase
  end

endmodule

/* src/booth_mul.sv */
// Radix-4 Booth sequential multiplier with INIT/PROG/FINAL sequencer
`timescale 1ns/1ps

module booth_mul (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             flush,
  input  logic             start,
  input  logic             hold,
  input  logic [1:0]       sel,
  input  mcalu_pkg::word_t op1,
  input  mcalu_pkg::word_t op2,
  output logic             done,
  output mcalu_pkg::word_t product
);

  mcalu_pkg::mc_state_t state;
  logic [$clog2(mcalu_pkg::MUL_ITERS)-1:0] iter;

  // High 34 bits collect partial sums, low 32 start as the multiplier
  logic [65:0] acc;
  logic        x0;
  logic [32:0] mcand;
  logic [1:0]  sel_q;

  logic        mcand_signed;
  logic        b1;
  logic        b0;
  logic        single;
  logic        double;
  logic        neg;
  logic [35:0] pp_mag;
  logic [35:0] pp;
  logic [35:0] sum;
  logic [33:0] hi_fix;

  // MULHU treats op1 as unsigned, everything else sign-extends it
  assign mcand_signed = (sel != 2'b11);

  // Booth digit from two new multiplier bits and the previous top bit
  assign {b1, b0} = acc[1:0];
  assign single = b0 ^ x0;
  assign double = (~b1 & b0 & x0) | (b1 & ~b0 & ~x0);
  assign neg    = b1;

  always_comb begin
    if (single) begin
      pp_mag = {{3{mcand[32]}}, mcand};
    end else if (double) begin
      pp_mag = {{2{mcand[32]}}, mcand, 1'b0};
    end else begin
      pp_mag = '0;
    end
  end

  // Ones complement here, the +1 goes in as carry
  assign pp  = pp_mag ^ {36{neg}};
  assign sum = {{2{acc[65]}}, acc[65:32]} + pp + {35'b0, neg};

  // Unsigned multiplier with top bit set needs one more multiplicand at 2^32
  assign hi_fix  = acc[65:32] + ((x0 & sel_q[1]) ? {mcand[32], mcand} : 34'b0);
  assign product = (sel_q == 2'b00) ? acc[31:0] : hi_fix[31:0];
  assign done    = (state == mcalu_pkg::FINAL);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= mcalu_pkg::INIT;
      iter  <= '0;
    end else if (flush) begin
      state <= mcalu_pkg::INIT;
      iter  <= '0;
    end else begin
      case (state)
        mcalu_pkg::INIT: begin
          if (start) begin
            state <= mcalu_pkg::PROG;
            iter  <= '0;
          end
        end
        mcalu_pkg::PROG: begin
          iter <= iter + 1'b1;
          if (int'(iter) == mcalu_pkg::MUL_ITERS - 1) begin
            state <= mcalu_pkg::FINAL;
          end
        end
        mcalu_pkg::FINAL: begin
          if (!hold) begin
            state <= mcalu_pkg::INIT;
          end
        end
        default: begin
          state <= mcalu_pkg::INIT;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == mcalu_pkg::INIT && start) begin
      acc   <= {34'b0, op2};
      x0    <= 1'b0;
      mcand <= {mcand_signed & op1[31], op1};
      sel_q <= sel;
    end else if (state == mcalu_pkg::PROG) begin
      // Add then arithmetic shift by two
      acc <= {sum, acc[31:2]};
      x0  <= acc[1];
    end
  end

endmodule

/* src/restoring_div.sv */
// Restoring sequential divider with sign fixup and RISC-V corner cases
`timescale 1ns/1ps

module restoring_div (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             flush,
  input  logic             start,
  input  logic             hold,
  input  logic [1:0]       sel,
  input  mcalu_pkg::word_t dividend,
  input  mcalu_pkg::word_t divisor,
  output logic             done,
  output mcalu_pkg::word_t quotient_rem
);

  mcalu_pkg::mc_state_t state;
  logic [$clog2(mcalu_pkg::DIV_ITERS)-1:0] iter;

  // Remainder in the upper half, dividend shifting into quotient below
  logic [63:0]      rq;
  mcalu_pkg::word_t dsr;
  logic             dvd_neg;
  logic             dsr_neg;
  logic             div_zero;
  logic             want_rem;

  logic             is_signed;
  mcalu_pkg::word_t dvd_mag;
  mcalu_pkg::word_t dsr_mag;
  logic [63:0]      shifted;
  logic [32:0]      trial;
  mcalu_pkg::word_t q_raw;
  mcalu_pkg::word_t r_raw;
  mcalu_pkg::word_t quot;
  mcalu_pkg::word_t rem;

  // DIV and REM are the signed variants
  assign is_signed = ~sel[0];
  assign dvd_mag   = (is_signed & dividend[31]) ? -dividend : dividend;
  assign dsr_mag   = (is_signed & divisor[31]) ? -divisor : divisor;

  // Trial subtract, a borrow means restore
  assign shifted = {rq[62:0], 1'b0};
  assign trial   = {1'b0, shifted[63:32]} - {1'b0, dsr};

  assign q_raw = rq[31:0];
  assign r_raw = rq[63:32];

  // Most-negative by minus one yields 2^31 magnitude, which negates to itself
  assign quot = div_zero ? '1 : ((dvd_neg ^ dsr_neg) ? -q_raw : q_raw);

  // Remainder follows the dividend sign, also covers divide by zero
  assign rem = dvd_neg ? -r_raw : r_raw;

  assign quotient_rem = want_rem ? rem : quot;
  assign done         = (state == mcalu_pkg::FINAL);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= mcalu_pkg::INIT;
      iter  <= '0;
    end else if (flush) begin
      state <= mcalu_pkg::INIT;
      iter  <= '0;
    end else begin
      case (state)
        mcalu_pkg::INIT: begin
          if (start) begin
            state <= mcalu_pkg::PROG;
            iter  <= '0;
          end
        end
        mcalu_pkg::PROG: begin
          iter <= iter + 1'b1;
          if (int'(iter) == mcalu_pkg::DIV_ITERS - 1) begin
            state <= mcalu_pkg::FINAL;
          end
        end
        mcalu_pkg::FINAL: begin
          if (!hold) begin
            state <= mcalu_pkg::INIT;
          end
        end
        default: begin
          state <= mcalu_pkg::INIT;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == mcalu_pkg::INIT && start) begin
      rq       <= {32'b0, dvd_mag};
      dsr      <= dsr_mag;
      dvd_neg  <= is_signed & dividend[31];
      dsr_neg  <= is_signed & divisor[31];
      div_zero <= (divisor == '0);
      want_rem <= sel[1];
    end else if (state == mcalu_pkg::PROG) begin
      rq <= trial[32] ? shifted : {trial[31:0], shifted[31:1], 1'b1};
    end
  end

endmodule

/* src/mcalu.sv */
// Execution unit top level with issue latch, stall logic, unit dispatch and result mux
`timescale 1ns/1ps

module mcalu (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                flush,

  // Issue side
  input  logic                issue,
  input  mcalu_pkg::alu_op_t  op,
  input  mcalu_pkg::robid_t   robid,
  input  mcalu_pkg::rd_t      rd,
  input  mcalu_pkg::word_t    op1,
  input  mcalu_pkg::word_t    op2,
  output logic                stall,

  // Writeback side
  output logic                result_valid,
  output mcalu_pkg::robid_t   result_robid,
  output mcalu_pkg::rd_t      result_rd,
  output mcalu_pkg::word_t    result,
  input  logic                wb_stall
);

  logic               valid;
  logic               fresh;
  logic               accept;

  mcalu_pkg::alu_op_t op_q;
  mcalu_pkg::robid_t  robid_q;
  mcalu_pkg::rd_t     rd_q;
  mcalu_pkg::word_t   op1_q;
  mcalu_pkg::word_t   op2_q;

  logic               is_mc;
  logic               is_mul;
  logic               is_div;
  logic               mul_start;
  logic               div_start;
  logic               mul_done;
  logic               div_done;
  logic               done;

  mcalu_pkg::word_t   sc_result;
  mcalu_pkg::word_t   mul_product;
  mcalu_pkg::word_t   div_result;

  // Decode of the held opcode
  assign is_mc  = &op_q[4:3];
  assign is_mul = is_mc & ~op_q[2];
  assign is_div = is_mc & op_q[2];

  // Single-cycle results are ready as soon as the op is held
  assign done = is_mc ? (op_q[2] ? div_done : mul_done) : 1'b1;

  // Busy or blocked at writeback
  assign stall  = valid & (~done | wb_stall);
  assign accept = issue & ~stall;

  // Start pulse only in the first cycle after accept
  assign mul_start = fresh & is_mul;
  assign div_start = fresh & is_div;

  assign result_valid = valid & done;
  assign result_robid = robid_q;
  assign result_rd    = rd_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid <= 1'b0;
      fresh <= 1'b0;
    end else if (flush) begin
      valid <= 1'b0;
      fresh <= 1'b0;
    end else begin
      fresh <= accept;
      if (!stall) begin
        valid <= issue;
      end
    end
  end

  // Issue payload
  always_ff @(posedge clk) begin
    if (accept) begin
      op_q    <= op;
      robid_q <= robid;
      rd_q    <= rd;
      op1_q   <= op1;
      op2_q   <= op2;
    end
  end

  alu_simple i_alu_simple (
    .op        (op_q),
    .op1       (op1_q),
    .op2       (op2_q),
    .sc_result (sc_result)
  );

  booth_mul i_booth_mul (
    .clk     (clk),
    .rst_n   (rst_n),
    .flush   (flush),
    .start   (mul_start),
    .hold    (wb_stall),
    .sel     (op_q[1:0]),
    .op1     (op1_q),
    .op2     (op2_q),
    .done    (mul_done),
    .product (mul_product)
  );

  restoring_div i_restoring_div (
    .clk          (clk),
    .rst_n        (rst_n),
    .flush        (flush),
    .start        (div_start),
    .hold         (wb_stall),
    .sel          (op_q[1:0]),
    .dividend     (op1_q),
    .divisor      (op2_q),
    .done         (div_done),
    .quotient_rem (div_result)
  );

  always_comb begin
    if (is_div) begin
      result = div_result;
    end else if (is_mul) begin
      result = mul_product;
    end else begin
      result = sc_result;
    end
  end

endmodule

/* tb/tb_clkgen.sv */
// Testbench clock and power-on reset source
`timescale 1ns/1ps

module tb_clkgen (
  output logic clk,
  output logic rst_n
);

  // 10 ns period
  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Reset covers the first five rising edges, released on a falling edge
  initial begin
    rst_n = 1'b0;
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

/* tb/mcalu_chk.sv */
// Handshake assertions for the execution unit and their bind into mcalu
`timescale 1ns/1ps

module mcalu_chk (
  input logic              clk,
  input logic              rst_n,
  input logic              flush,
  input logic              stall,
  input logic              result_valid,
  input mcalu_pkg::robid_t result_robid,
  input mcalu_pkg::rd_t    result_rd,
  input mcalu_pkg::word_t  result,
  input logic              wb_stall
);

  // Failure counts, summed by the testbench at the end
  int flush_fails = 0;
  int hold_fails = 0;
  int accept_fails = 0;

  // Unit is empty one cycle after a flush
  a_flush_empties: assert property (@(posedge clk) disable iff (!rst_n)
    flush |=> (!stall && !result_valid))
    else begin
      flush_fails = flush_fails + 1;
      $error("stall or result_valid still high in the cycle after a flush");
    end

  // Result frozen while writeback holds it off
  a_result_held: assert property (@(posedge clk) disable iff (!rst_n)
    (result_valid && wb_stall && !flush) |=>
      (result_valid && $stable(result) && $stable(result_robid) && $stable(result_rd)))
    else begin
      hold_fails = hold_fails + 1;
      $error("result outputs changed while wb_stall was high");
    end

  // Tag and destination only move on an accept
  a_no_accept_stalled: assert property (@(posedge clk) disable iff (!rst_n)
    stall |=> ($stable(result_robid) && $stable(result_rd)))
    else begin
      accept_fails = accept_fails + 1;
      $error("operation accepted while stall was high");
    end

endmodule

bind mcalu mcalu_chk i_mcalu_chk (
  .clk          (clk),
  .rst_n        (rst_n),
  .flush        (flush),
  .stall        (stall),
  .result_valid (result_valid),
  .result_robid (result_robid),
  .result_rd    (result_rd),
  .result       (result),
  .wb_stall     (wb_stall)
);

/* tb/mcalu_tb.sv */
// Testbench top with LCG stimulus, reference model, result checks, timeout and summary
`timescale 1ns/1ps

module mcalu_tb;

  localparam int SC_OPS     = 200;
  localparam int UNK_OPS    = 20;
  localparam int MUL_OPS    = 100;
  localparam int DIV_OPS    = 100;
  localparam int BP_OPS     = 100;
  localparam int FLUSH_RUNS = 4;
  // Six fixed divide corners, two ops per flush round
  localparam int TOTAL_OPS  = SC_OPS + UNK_OPS + MUL_OPS + DIV_OPS + 6 + BP_OPS + 2 * FLUSH_RUNS;
  localparam int TIMEOUT_CYCLES = TOTAL_OPS * 40 + 1000;

  logic               clk;
  logic               rst_n;
  logic               flush;
  logic               issue;
  logic               stall;
  logic               result_valid;
  logic               wb_stall;
  mcalu_pkg::alu_op_t op;
  mcalu_pkg::robid_t  robid;
  mcalu_pkg::rd_t     rd;
  mcalu_pkg::word_t   op1;
  mcalu_pkg::word_t   op2;
  mcalu_pkg::robid_t  result_robid;
  mcalu_pkg::rd_t     result_rd;
  mcalu_pkg::word_t   result;

  logic [31:0] seed = 32'h57b1_0f9b;

  // Operation waiting at the issue port
  logic               have_op;
  mcalu_pkg::alu_op_t cur_op;
  mcalu_pkg::robid_t  cur_robid;
  mcalu_pkg::rd_t     cur_rd;
  mcalu_pkg::word_t   cur_op1;
  mcalu_pkg::word_t   cur_op2;
  mcalu_pkg::robid_t  next_tag;

  // Operation held inside the DUT
  logic               pending;
  mcalu_pkg::robid_t  exp_robid;
  mcalu_pkg::rd_t     exp_rd;
  mcalu_pkg::word_t   exp_result;

  // Discarded tag that must never come back
  logic               flushed_valid;
  mcalu_pkg::robid_t  flushed_tag;

  logic  flush_req;
  int    bp_pct;
  string test_name;
  int    issued;
  int    consumed;
  int    test_errors;
  int    total_errors;
  int    tests_run;
  int    tests_failed;
  int    assert_total;
  int    cycle_count;

  tb_clkgen i_clkgen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  mcalu i_dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .flush        (flush),
    .issue        (issue),
    .op           (op),
    .robid        (robid),
    .rd           (rd),
    .op1          (op1),
    .op2          (op2),
    .stall        (stall),
    .result_valid (result_valid),
    .result_robid (result_robid),
    .result_rd    (result_rd),
    .result       (result),
    .wb_stall     (wb_stall)
  );

  function automatic logic [31:0] rand_word();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  // Upper LCG bits only, the low ones cycle quickly
  function automatic int rand_below(input int n);
    return int'((rand_word() >> 8) % n);
  endfunction

  function automatic mcalu_pkg::word_t rand_data();
    logic [31:0] r1;
    logic [31:0] r2;
    r1 = rand_word();
    r2 = rand_word();
    return {r1[31:16], r2[31:16]};
  endfunction

  // Leans toward zero, minus one and the most negative word
  function automatic mcalu_pkg::word_t edge_data();
    case (rand_below(8))
      0: return 32'h0000_0000;
      1: return 32'hffff_ffff;
      2: return 32'h8000_0000;
      3: return 32'h0000_0001;
      default: return rand_data();
    endcase
  endfunction

  function automatic mcalu_pkg::word_t model_result(input mcalu_pkg::alu_op_t code,
                                                    input mcalu_pkg::word_t a,
                                                    input mcalu_pkg::word_t b);
    logic [63:0]        sa;
    logic [63:0]        sb;
    logic [63:0]        prod;
    logic               ovf;
    logic signed [31:0] squot;
    logic signed [31:0] srem;
    mcalu_pkg::word_t   res;
    sa    = {{32{a[31]}}, a};
    sb    = {{32{b[31]}}, b};
    prod  = 64'd0;
    ovf   = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
    squot = 32'sd0;
    srem  = 32'sd0;
    // Truncating signed quotient and remainder for the regular cases
    if (b != 0 && !ovf) begin
      squot = $signed(a) / $signed(b);
      srem  = $signed(a) % $signed(b);
    end
    case (code)
      mcalu_pkg::OP_ADD:  res = a + b;
      mcalu_pkg::OP_SUB:  res = a - b;
      mcalu_pkg::OP_SLL:  res = a << b[4:0];
      mcalu_pkg::OP_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      mcalu_pkg::OP_SLTU: res = (a < b) ? 32'd1 : 32'd0;
      mcalu_pkg::OP_XOR:  res = a ^ b;
      mcalu_pkg::OP_SRL:  res = a >> b[4:0];
      mcalu_pkg::OP_SRA:  res = $signed(a) >>> b[4:0];
      mcalu_pkg::OP_OR:   res = a | b;
      mcalu_pkg::OP_AND:  res = a & b;
      mcalu_pkg::OP_MUL: begin
        prod = sa * sb;
        res  = prod[31:0];
      end
      mcalu_pkg::OP_MULH: begin
        prod = sa * sb;
        res  = prod[63:32];
      end
      mcalu_pkg::OP_MULHSU: begin
        prod = sa * {32'd0, b};
        res  = prod[63:32];
      end
      mcalu_pkg::OP_MULHU: begin
        prod = {32'd0, a} * {32'd0, b};
        res  = prod[63:32];
      end
      mcalu_pkg::OP_DIV:  res = (b == 0) ? 32'hffff_ffff : (ovf ? a : squot);
      mcalu_pkg::OP_DIVU: res = (b == 0) ? 32'hffff_ffff : a / b;
      mcalu_pkg::OP_REM:  res = (b == 0) ? a : (ovf ? 32'd0 : srem);
      mcalu_pkg::OP_REMU: res = (b == 0) ? a : a % b;
      default:            res = 32'd0;
    endcase
    return res;
  endfunction

  task automatic report_value(input string what, input logic [31:0] expv,
                              input logic [31:0] actv);
    $display("FAILED %s %s: expected 0x%08h actual 0x%08h", test_name, what, expv, actv);
    test_errors++;
  endtask

  task automatic report_plain(input string msg);
    $display("Error in %s: %s", test_name, msg);
    test_errors++;
  endtask

  task automatic check_result();
    if (flushed_valid && result_robid == flushed_tag) begin
      report_plain("a result came back for a flushed tag");
    end
    if (!pending) begin
      report_plain("result_valid high with no operation outstanding");
    end else begin
      if (result != exp_result) begin
        report_value("result", exp_result, result);
      end
      if (result_robid != exp_robid) begin
        report_value("robid", 32'(exp_robid), 32'(result_robid));
      end
      if (result_rd != exp_rd) begin
        report_value("rd", 32'(exp_rd), 32'(result_rd));
      end
      pending = 1'b0;
      consumed++;
    end
  endtask

  // Drive on the falling edge, then judge the coming rising edge from settled values
  task automatic tick();
    @(negedge clk);
    flush    = flush_req;
    issue    = have_op && !flush_req;
    op       = cur_op;
    robid    = cur_robid;
    rd       = cur_rd;
    op1      = cur_op1;
    op2      = cur_op2;
    wb_stall = flush_req || (rand_below(100) < bp_pct);
    #1;
    if (flush_req) begin
      // Dropped op owes no result
      if (pending) begin
        issued--;
      end
      pending   = 1'b0;
      flush_req = 1'b0;
    end else begin
      if (result_valid && !wb_stall) begin
        check_result();
      end
      if (issue && !stall) begin
        pending    = 1'b1;
        exp_robid  = cur_robid;
        exp_rd     = cur_rd;
        exp_result = model_result(cur_op, cur_op1, cur_op2);
        have_op    = 1'b0;
        issued++;
      end
    end
  endtask

  task automatic send_op(input mcalu_pkg::alu_op_t code, input mcalu_pkg::word_t a,
                         input mcalu_pkg::word_t b);
    cur_op    = code;
    cur_op1   = a;
    cur_op2   = b;
    cur_robid = next_tag;
    cur_rd    = mcalu_pkg::rd_t'(rand_below(64));
    next_tag  = next_tag + 1'b1;
    have_op   = 1'b1;
    while (have_op) begin
      tick();
    end
  endtask

  task automatic drain();
    while (pending) begin
      tick();
    end
  endtask

  task automatic begin_test(input string name);
    test_name   = name;
    test_errors = 0;
    issued      = 0;
    consumed    = 0;
  endtask

  task automatic end_test();
    drain();
    // Extra cycle catches a stray result
    tick();
    if (issued != consumed) begin
      report_value("result count", 32'(issued), 32'(consumed));
    end
    $display("test %-13s %0d results, %0d errors", test_name, consumed, test_errors);
    tests_run++;
    total_errors += test_errors;
    if (test_errors != 0) begin
      tests_failed++;
    end
  endtask

  // Limit scales with the operation count
  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Something failed");
    $finish;
  end

  initial begin
    flush         = 1'b0;
    issue         = 1'b0;
    op            = '0;
    robid         = '0;
    rd            = '0;
    op1           = '0;
    op2           = '0;
    wb_stall      = 1'b0;
    have_op       = 1'b0;
    cur_op        = '0;
    cur_robid     = '0;
    cur_rd        = '0;
    cur_op1       = '0;
    cur_op2       = '0;
    next_tag      = '0;
    pending       = 1'b0;
    flushed_valid = 1'b0;
    flushed_tag   = '0;
    flush_req     = 1'b0;
    bp_pct        = 0;
    total_errors  = 0;
    tests_run     = 0;
    tests_failed  = 0;
    wait (rst_n);
    tick();

    begin_test("single_cycle");
    for (int i = 0; i < SC_OPS; i++) begin
      send_op(mcalu_pkg::alu_op_t'(rand_below(10)), rand_data(), rand_data());
    end
    // Codes 10 to 23 are unassigned
    for (int i = 0; i < UNK_OPS; i++) begin
      send_op(mcalu_pkg::alu_op_t'(10 + rand_below(14)), rand_data(), rand_data());
    end
    end_test();

    begin_test("multiply");
    for (int i = 0; i < MUL_OPS; i++) begin
      send_op(mcalu_pkg::alu_op_t'(24 + rand_below(4)), edge_data(), edge_data());
    end
    end_test();

    begin_test("divide");
    send_op(mcalu_pkg::OP_DIV, rand_data(), 32'd0);
    send_op(mcalu_pkg::OP_REM, rand_data(), 32'd0);
    send_op(mcalu_pkg::OP_DIVU, rand_data(), 32'd0);
    send_op(mcalu_pkg::OP_REMU, rand_data(), 32'd0);
    send_op(mcalu_pkg::OP_DIV, 32'h8000_0000, 32'hffff_ffff);
    send_op(mcalu_pkg::OP_REM, 32'h8000_0000, 32'hffff_ffff);
    for (int i = 0; i < DIV_OPS; i++) begin
      send_op(mcalu_pkg::alu_op_t'(28 + rand_below(4)), edge_data(), edge_data());
    end
    end_test();

    begin_test("backpressure");
    bp_pct = 40;
    for (int i = 0; i < BP_OPS; i++) begin
      send_op(mcalu_pkg::alu_op_t'(rand_below(2) == 0 ? rand_below(10) : 24 + rand_below(8)),
              edge_data(), edge_data());
    end
    end_test();
    bp_pct = 0;

    begin_test("flush");
    for (int i = 0; i < FLUSH_RUNS; i++) begin
      send_op(mcalu_pkg::alu_op_t'(24 + rand_below(8)), rand_data(), rand_data());
      flushed_tag   = cur_robid;
      flushed_valid = 1'b1;
      // Well inside the shortest multi-cycle latency
      repeat (1 + rand_below(8)) begin
        tick();
      end
      flush_req = 1'b1;
      tick();
      send_op(mcalu_pkg::alu_op_t'(24 + rand_below(8)), rand_data(), rand_data());
      drain();
    end
    end_test();
    flushed_valid = 1'b0;

    assert_total = i_dut.i_mcalu_chk.flush_fails + i_dut.i_mcalu_chk.hold_fails
                 + i_dut.i_mcalu_chk.accept_fails;
    $display("tests %0d, failed %0d, check errors %0d, assertion failures %0d",
             tests_run, tests_failed, total_errors, assert_total);
    if (total_errors == 0 && tests_failed == 0 && assert_total == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

/* project.f */
src/mcalu_pkg.sv
src/alu_simple.sv
src/booth_mul.sv
src/restoring_div.sv
src/mcalu.sv
tb/tb_clkgen.sv
tb/mcalu_chk.sv
tb/mcalu_tb.sv

/* run.sh */
#!/bin/sh
# Build the mcalu testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module mcalu_tb -o mcalu_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

# Let assertion errors accumulate so the testbench summary is reached
./obj_dir/mcalu_sim +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Something failed" sim.log; then
  exit 1
fi
exit 0
